//--- src/obi_pkg.sv
/* OBI bus package
   bus widths and the request and response structs used by both link ports */
package obi_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // master to target, valid while req is high
  typedef struct packed {
    logic                req;
    logic [ADDR_W-1:0]   addr;
    logic                we;
    logic [DATA_W/8-1:0] be;
    logic [DATA_W-1:0]   wdata;
  } obi_req_t;

  // target to master
  // gnt in the request cycle, rvalid one cycle after acceptance
  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
  } obi_rsp_t;

endpackage

//--- src/sl_pkg.sv
/* serial link package
   link defaults, register offsets and the receive side entry and status types */
package sl_pkg;

  // default lane count and queue depth
  localparam int NUM_LANES  = 4;
  localparam int FIFO_DEPTH = 8;

  // offsets are decoded from the low address bits only
  localparam int REG_OFS_W = 4;
  localparam logic [REG_OFS_W-1:0] REG_DATA   = 'h0;
  localparam logic [REG_OFS_W-1:0] REG_STATUS = 'h4;

  // width of the count field in the status word
  localparam int STS_CNT_W = 4;

  // one received word with its parity check result
  typedef struct packed {
    logic        par_err;
    logic [31:0] data;
  } rx_entry_t;

  // status word of the receive port, fills 32 bits
  typedef struct packed {
    logic [23-STS_CNT_W:0] rsvd_hi;
    logic [STS_CNT_W-1:0]  count;
    logic [4:0]            rsvd_lo;
    logic                  overflow;
    logic                  head_par_err;
    logic                  not_empty;
  } rx_status_t;

endpackage

//--- src/sl_fifo.sv
`timescale 1ns/1ps

/* synchronous FIFO
   circular buffer with a generic payload type, head shown on data_o */
module sl_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 8
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         push_i,
  input  payload_t                     data_i,
  input  logic                         pop_i,
  output payload_t                     data_o,
  output logic                         full_o,
  output logic                         empty_o,
  output logic [$clog2(DEPTH+1)-1:0]   count_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  // wrap explicitly, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // simultaneous push and pop leaves the count alone
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign data_o  = mem_q[rd_ptr_q];
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign count_o = count_q;

endmodule

//--- src/sl_tx_port.sv
`timescale 1ns/1ps

/* serial link transmit port
   OBI target that queues words written to the data offset for the serializer */
module sl_tx_port (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  obi_pkg::obi_req_t          req_i,
  output obi_pkg::obi_rsp_t          rsp_o,
  input  logic                       fifo_full_i,
  output logic                       push_o,
  output logic [obi_pkg::DATA_W-1:0] push_data_o
);
  import obi_pkg::*;
  import sl_pkg::*;

  logic     gnt;
  logic     accept;
  logic     is_data;
  logic     rvalid_q;
  obi_rsp_t rsp;

  // hold off the master while the queue has no room
  assign gnt     = req_i.req && !fifo_full_i;
  assign accept  = req_i.req && gnt;
  assign is_data = (req_i.addr[REG_OFS_W-1:0] == REG_DATA);

  // only a data write queues a word, everything else just completes
  assign push_o      = accept && req_i.we && is_data;
  assign push_data_o = req_i.wdata;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= accept;
    end
  end

  always_comb begin
    rsp        = '0;
    rsp.gnt    = gnt;
    rsp.rvalid = rvalid_q;
    // nothing readable on this port
    rsp.rdata  = '0;
  end

  assign rsp_o = rsp;

endmodule

//--- src/sl_serializer.sv
`timescale 1ns/1ps

/* serial link serializer
   shifts each word out LSB nibble first across the lanes, then one parity beat */
module sl_serializer #(
  parameter int NUM_LANES = sl_pkg::NUM_LANES
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic [obi_pkg::DATA_W-1:0] word_i,
  input  logic                       word_avail_i,
  output logic                       pop_o,
  output logic                       ser_valid_o,
  output logic [NUM_LANES-1:0]       ser_data_o
);
  import obi_pkg::*;

  localparam int BEATS = DATA_W / NUM_LANES;
  localparam int CNT_W = $clog2(BEATS + 1);

  logic [DATA_W-1:0] shift_q;
  logic              parity_q;
  logic [CNT_W-1:0]  beat_q;
  logic              busy_q;
  logic              par_beat;
  logic              load;

  // beat index BEATS is the parity beat
  assign par_beat = busy_q && (beat_q == CNT_W'(BEATS));

  // next word is taken during the parity beat so words run back to back
  assign load  = word_avail_i && (!busy_q || par_beat);
  assign pop_o = load;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      beat_q <= '0;
    end else if (load) begin
      busy_q <= 1'b1;
      beat_q <= '0;
    end else if (par_beat) begin
      busy_q <= 1'b0;
      beat_q <= '0;
    end else if (busy_q) begin
      beat_q <= beat_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      shift_q  <= word_i;
      parity_q <= ^word_i;
    end else if (busy_q) begin
      shift_q <= shift_q >> NUM_LANES;
    end
  end

  assign ser_valid_o = busy_q;

  // parity rides on lane 0, the other lanes stay low
  always_comb begin
    if (!busy_q) begin
      ser_data_o = '0;
    end else if (par_beat) begin
      ser_data_o = NUM_LANES'(parity_q);
    end else begin
      ser_data_o = shift_q[NUM_LANES-1:0];
    end
  end

endmodule

//--- src/sl_deserializer.sv
`timescale 1ns/1ps

/* serial link deserializer
   rebuilds words from lane beats, checks even parity and feeds the receive FIFO */
module sl_deserializer #(
  parameter int NUM_LANES = sl_pkg::NUM_LANES
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 ser_valid_i,
  input  logic [NUM_LANES-1:0] ser_data_i,
  input  logic                 fifo_full_i,
  output logic                 push_o,
  output sl_pkg::rx_entry_t    entry_o,
  output logic                 drop_o
);
  import obi_pkg::*;
  import sl_pkg::*;

  localparam int BEATS = DATA_W / NUM_LANES;
  localparam int CNT_W = $clog2(BEATS + 1);

  logic [DATA_W-1:0] word_q;
  logic [CNT_W-1:0]  beat_q;
  logic              par_beat;
  logic              done_q;
  rx_entry_t         entry_q;

  // after BEATS data beats the next valid beat carries parity
  assign par_beat = ser_valid_i && (beat_q == CNT_W'(BEATS));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      beat_q <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= par_beat;
      if (par_beat) begin
        beat_q <= '0;
      end else if (ser_valid_i) begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  // first beat lands in the low nibble once all beats are in
  always_ff @(posedge clk_i) begin
    if (ser_valid_i && !par_beat) begin
      word_q <= {ser_data_i, word_q[DATA_W-1:NUM_LANES]};
    end
    if (par_beat) begin
      entry_q.data    <= word_q;
      entry_q.par_err <= (^word_q) ^ ser_data_i[0];
    end
  end

  // a full receive queue loses the word
  assign push_o  = done_q && !fifo_full_i;
  assign drop_o  = done_q && fifo_full_i;
  assign entry_o = entry_q;

endmodule

//--- src/sl_rx_port.sv
`timescale 1ns/1ps

/* serial link receive port
   OBI target that pops received words, reports status and keeps the overflow flag */
module sl_rx_port #(
  parameter int FIFO_DEPTH = sl_pkg::FIFO_DEPTH
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  obi_pkg::obi_req_t                 req_i,
  output obi_pkg::obi_rsp_t                 rsp_o,
  input  sl_pkg::rx_entry_t                 head_i,
  input  logic                              empty_i,
  input  logic [$clog2(FIFO_DEPTH+1)-1:0]   count_i,
  input  logic                              drop_i,
  output logic                              pop_o
);
  import obi_pkg::*;
  import sl_pkg::*;

  logic              rd_data;
  logic              rd_status;
  logic              overflow_q;
  logic              rvalid_q;
  logic [DATA_W-1:0] rdata_d;
  logic [DATA_W-1:0] rdata_q;
  rx_status_t        status;

  // never stalls, writes complete without effect
  assign rd_data   = req_i.req && !req_i.we && (req_i.addr[REG_OFS_W-1:0] == REG_DATA);
  assign rd_status = req_i.req && !req_i.we && (req_i.addr[REG_OFS_W-1:0] == REG_STATUS);
  assign pop_o     = rd_data && !empty_i;

  always_comb begin
    status              = '0;
    status.not_empty    = !empty_i;
    status.head_par_err = !empty_i && head_i.par_err;
    status.overflow     = overflow_q;
    status.count        = STS_CNT_W'(count_i);
  end

  // empty data read returns zero
  always_comb begin
    rdata_d = '0;
    if (pop_o) begin
      rdata_d = head_i.data;
    end else if (rd_status) begin
      rdata_d = status;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q   <= 1'b0;
      overflow_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
      // a drop in the read cycle survives to the next status read
      if (drop_i) begin
        overflow_q <= 1'b1;
      end else if (rd_status) begin
        overflow_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= rdata_d;
    end
  end

  assign rsp_o.gnt    = req_i.req;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;

endmodule

//--- src/serial_link_top.sv
`timescale 1ns/1ps

/* serial link top
   transmit port, FIFO and serializer on the send side, mirrored on the receive side */
module serial_link_top #(
  parameter int NUM_LANES  = sl_pkg::NUM_LANES,
  parameter int FIFO_DEPTH = sl_pkg::FIFO_DEPTH
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  obi_pkg::obi_req_t    tx_req_i,
  output obi_pkg::obi_rsp_t    tx_rsp_o,
  input  obi_pkg::obi_req_t    rx_req_i,
  output obi_pkg::obi_rsp_t    rx_rsp_o,
  output logic                 ser_valid_o,
  output logic [NUM_LANES-1:0] ser_data_o,
  input  logic                 ser_valid_i,
  input  logic [NUM_LANES-1:0] ser_data_i
);
  import obi_pkg::*;
  import sl_pkg::*;

  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  // send side
  logic              tx_push;
  logic              tx_pop;
  logic              tx_full;
  logic              tx_empty;
  logic [DATA_W-1:0] tx_push_data;
  logic [DATA_W-1:0] tx_head;

  // receive side
  logic              rx_push;
  logic              rx_pop;
  logic              rx_full;
  logic              rx_empty;
  logic              rx_drop;
  logic [CNT_W-1:0]  rx_count;
  rx_entry_t         rx_entry;
  rx_entry_t         rx_head;

  sl_tx_port sl_tx_port_i (
    .clk_i,
    .rst_n_i,
    .req_i       (tx_req_i),
    .rsp_o       (tx_rsp_o),
    .fifo_full_i (tx_full),
    .push_o      (tx_push),
    .push_data_o (tx_push_data)
  );

  sl_fifo #(
    .payload_t (logic [DATA_W-1:0]),
    .DEPTH     (FIFO_DEPTH)
  ) tx_fifo_i (
    .clk_i,
    .rst_n_i,
    .push_i  (tx_push),
    .data_i  (tx_push_data),
    .pop_i   (tx_pop),
    .data_o  (tx_head),
    .full_o  (tx_full),
    .empty_o (tx_empty),
    .count_o ()
  );

  sl_serializer #(
    .NUM_LANES (NUM_LANES)
  ) sl_serializer_i (
    .clk_i,
    .rst_n_i,
    .word_i       (tx_head),
    .word_avail_i (!tx_empty),
    .pop_o        (tx_pop),
    .ser_valid_o,
    .ser_data_o
  );

  sl_deserializer #(
    .NUM_LANES (NUM_LANES)
  ) sl_deserializer_i (
    .clk_i,
    .rst_n_i,
    .ser_valid_i,
    .ser_data_i,
    .fifo_full_i (rx_full),
    .push_o      (rx_push),
    .entry_o     (rx_entry),
    .drop_o      (rx_drop)
  );

  sl_fifo #(
    .payload_t (rx_entry_t),
    .DEPTH     (FIFO_DEPTH)
  ) rx_fifo_i (
    .clk_i,
    .rst_n_i,
    .push_i  (rx_push),
    .data_i  (rx_entry),
    .pop_i   (rx_pop),
    .data_o  (rx_head),
    .full_o  (rx_full),
    .empty_o (rx_empty),
    .count_o (rx_count)
  );

  sl_rx_port #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) sl_rx_port_i (
    .clk_i,
    .rst_n_i,
    .req_i   (rx_req_i),
    .rsp_o   (rx_rsp_o),
    .head_i  (rx_head),
    .empty_i (rx_empty),
    .count_i (rx_count),
    .drop_i  (rx_drop),
    .pop_o   (rx_pop)
  );

endmodule

//--- sim/sl_fifo_asserts.sv
`timescale 1ns/1ps

/* FIFO protocol checks
   flags pushes into a full FIFO, pops from an empty one and an out of range count */
module sl_fifo_asserts #(
  parameter int DEPTH = 8
) (
  input logic                       clk_i,
  input logic                       rst_n_i,
  input logic                       push_i,
  input logic                       pop_i,
  input logic                       full_i,
  input logic                       empty_i,
  input logic [$clog2(DEPTH+1)-1:0] count_i
);

  push_full_a: assert property (@(posedge clk_i) disable iff (!rst_n_i) push_i |-> !full_i)
    else $error("FIFO push while full");

  pop_empty_a: assert property (@(posedge clk_i) disable iff (!rst_n_i) pop_i |-> !empty_i)
    else $error("FIFO pop while empty");

  count_range_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    32'(count_i) <= DEPTH)
    else $error("FIFO count above depth");

endmodule

bind sl_fifo sl_fifo_asserts #(
  .DEPTH (DEPTH)
) sl_fifo_asserts_i (
  .clk_i   (clk_i),
  .rst_n_i (rst_n_i),
  .push_i  (push_i),
  .pop_i   (pop_i),
  .full_i  (full_o),
  .empty_i (empty_o),
  .count_i (count_o)
);

//--- sim/tb_clk_gen.sv
`timescale 1ns/1ps

/* testbench clock and reset
   free running clock, reset held low for a fixed number of cycles */
module tb_clk_gen #(
  parameter int HALF_PERIOD  = 10,
  parameter int RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // release on a falling edge, away from the DUT's sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

//--- sim/tb_serial_link.sv
`timescale 1ns/1ps

/* serial link testbench
   directed tests over a lane loopback that can corrupt lane 0 of one beat */
module tb_serial_link;
  import obi_pkg::*;
  import sl_pkg::*;

  localparam int LANES       = NUM_LANES;
  localparam int DEPTH       = FIFO_DEPTH;
  // data beats plus the parity beat
  localparam int WORD_BEATS  = DATA_W / LANES + 1;
  localparam int WAIT_CYCLES = 200;
  localparam int MAX_POLLS   = 100;
  localparam logic [ADDR_W-1:0] DATA_ADDR   = ADDR_W'(REG_DATA);
  localparam logic [ADDR_W-1:0] STATUS_ADDR = ADDR_W'(REG_STATUS);

  logic             clk;
  logic             rst_n;
  obi_req_t         tx_req;
  obi_rsp_t         tx_rsp;
  obi_req_t         rx_req;
  obi_rsp_t         rx_rsp;
  logic             ser_valid;
  logic [LANES-1:0] ser_data;
  logic [LANES-1:0] lane_in;
  logic             corrupt_req;
  logic             corrupt_done;
  logic             corrupt_now;
  int               beat_cnt;
  int               words_seen;
  integer           seed;
  int               test_errors;
  int               total_errors;
  int               tests_run;
  int               tests_failed;

  tb_clk_gen #(
    .HALF_PERIOD  (10),
    .RESET_CYCLES (10)
  ) clk_gen_i (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  serial_link_top #(
    .NUM_LANES  (LANES),
    .FIFO_DEPTH (DEPTH)
  ) UUT (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .tx_req_i    (tx_req),
    .tx_rsp_o    (tx_rsp),
    .rx_req_i    (rx_req),
    .rx_rsp_o    (rx_rsp),
    .ser_valid_o (ser_valid),
    .ser_data_o  (ser_data),
    .ser_valid_i (ser_valid),
    .ser_data_i  (lane_in)
  );

  // armed loopback flips lane 0 of the first beat only
  assign corrupt_now = corrupt_req && !corrupt_done && ser_valid;
  assign lane_in     = ser_data ^ LANES'(corrupt_now);

  always_ff @(posedge clk) begin
    if (!rst_n || !corrupt_req) begin
      corrupt_done <= 1'b0;
    end else if (ser_valid) begin
      corrupt_done <= 1'b1;
    end
  end

  // counts complete words on the lane
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beat_cnt   <= 0;
      words_seen <= 0;
    end else if (ser_valid) begin
      if (beat_cnt == WORD_BEATS - 1) begin
        beat_cnt   <= 0;
        words_seen <= words_seen + 1;
      end else begin
        beat_cnt <= beat_cnt + 1;
      end
    end
  end

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got === exp) else begin
      $display("mismatch %s got 0x%08h expected 0x%08h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic require(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("error: %s", what);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed with %0d errors", name, test_errors);
      tests_failed++;
    end
    total_errors += test_errors;
    test_errors = 0;
  endtask

  task automatic obi_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    int waited;
    @(negedge clk);
    tx_req.req   = 1'b1;
    tx_req.addr  = addr;
    tx_req.we    = 1'b1;
    tx_req.be    = '1;
    tx_req.wdata = data;
    #1;
    waited = 0;
    while (!tx_rsp.gnt && waited < WAIT_CYCLES) begin
      @(negedge clk);
      #1;
      waited++;
    end
    require(tx_rsp.gnt, "transmit port withheld the grant too long");
    @(negedge clk);
    tx_req = '0;
    waited = 0;
    while (!tx_rsp.rvalid && waited < WAIT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    require(tx_rsp.rvalid, "transmit port never returned rvalid");
  endtask

  task automatic read_tx_port(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    int waited;
    @(negedge clk);
    tx_req.req   = 1'b1;
    tx_req.addr  = addr;
    tx_req.we    = 1'b0;
    tx_req.be    = '1;
    tx_req.wdata = '0;
    #1;
    waited = 0;
    while (!tx_rsp.gnt && waited < WAIT_CYCLES) begin
      @(negedge clk);
      #1;
      waited++;
    end
    require(tx_rsp.gnt, "transmit port withheld the grant too long");
    @(negedge clk);
    tx_req = '0;
    waited = 0;
    while (!tx_rsp.rvalid && waited < WAIT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    require(tx_rsp.rvalid, "transmit port never returned rvalid");
    data = tx_rsp.rdata;
  endtask

  task automatic obi_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    int waited;
    @(negedge clk);
    rx_req.req   = 1'b1;
    rx_req.addr  = addr;
    rx_req.we    = 1'b0;
    rx_req.be    = '1;
    rx_req.wdata = '0;
    #1;
    waited = 0;
    while (!rx_rsp.gnt && waited < WAIT_CYCLES) begin
      @(negedge clk);
      #1;
      waited++;
    end
    require(rx_rsp.gnt, "receive port withheld the grant too long");
    @(negedge clk);
    rx_req = '0;
    waited = 0;
    while (!rx_rsp.rvalid && waited < WAIT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    require(rx_rsp.rvalid, "receive port never returned rvalid");
    data = rx_rsp.rdata;
  endtask

  // status polling clears overflow, so only used where no drop is expected
  task automatic wait_rx_count(input int target, output rx_status_t st);
    int                polls;
    logic [DATA_W-1:0] raw;
    polls = 0;
    st    = '0;
    while (!(st.not_empty && int'(st.count) >= target) && polls < MAX_POLLS) begin
      obi_read(STATUS_ADDR, raw);
      st = rx_status_t'(raw);
      polls++;
    end
    require(st.not_empty && int'(st.count) >= target, "received words did not arrive in time");
  endtask

  task automatic wait_lane_words(input int target);
    int waited;
    waited = 0;
    while (words_seen < target && waited < WAIT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    require(words_seen >= target, "words did not appear on the lane in time");
  endtask

  task automatic reset_state_test();
    logic [DATA_W-1:0] raw;
    compare_word("ser_valid_o", 32'(ser_valid), 32'h0);
    compare_word("ser_data_o", 32'(ser_data), 32'h0);
    compare_word("tx_rsp_o.rvalid", 32'(tx_rsp.rvalid), 32'h0);
    compare_word("rx_rsp_o.rvalid", 32'(rx_rsp.rvalid), 32'h0);
    // a read on the transmit port returns zero and queues nothing
    read_tx_port(DATA_ADDR, raw);
    compare_word("tx_rsp_o.rdata", raw, 32'h0);
    obi_read(STATUS_ADDR, raw);
    compare_word("status", raw, 32'h0);
    finish_test("reset_state");
  endtask

  task automatic single_word_loopback();
    logic [DATA_W-1:0] word;
    logic [DATA_W-1:0] raw;
    rx_status_t        st;
    word = $random(seed);
    obi_write(DATA_ADDR, word);
    wait_rx_count(1, st);
    compare_word("status.head_par_err", 32'(st.head_par_err), 32'h0);
    obi_read(DATA_ADDR, raw);
    compare_word("rx rdata", raw, word);
    finish_test("single_word_loopback");
  endtask

  task automatic burst_in_order();
    logic [DATA_W-1:0] sent [$];
    logic [DATA_W-1:0] word;
    logic [DATA_W-1:0] raw;
    rx_status_t        st;
    for (int i = 0; i < DEPTH; i++) begin
      word = $random(seed);
      sent.push_back(word);
      obi_write(DATA_ADDR, word);
    end
    wait_rx_count(DEPTH, st);
    compare_word("status.count", 32'(st.count), 32'(DEPTH));
    compare_word("status.head_par_err", 32'(st.head_par_err), 32'h0);
    for (int i = 0; i < DEPTH; i++) begin
      obi_read(DATA_ADDR, raw);
      compare_word("rx rdata", raw, sent[i]);
    end
    finish_test("burst_in_order");
  endtask

  task automatic parity_corruption();
    logic [DATA_W-1:0] word;
    logic [DATA_W-1:0] raw;
    rx_status_t        st;
    word = $random(seed);
    @(negedge clk);
    corrupt_req = 1'b1;
    obi_write(DATA_ADDR, word);
    wait_rx_count(1, st);
    compare_word("status.head_par_err", 32'(st.head_par_err), 32'h1);
    @(negedge clk);
    corrupt_req = 1'b0;
    obi_read(DATA_ADDR, raw);
    // lane 0 of the first beat is data bit 0
    compare_word("rx rdata", raw, word ^ 32'h1);
    word = $random(seed);
    obi_write(DATA_ADDR, word);
    wait_rx_count(1, st);
    compare_word("status.head_par_err", 32'(st.head_par_err), 32'h0);
    obi_read(DATA_ADDR, raw);
    compare_word("rx rdata", raw, word);
    finish_test("parity_corruption");
  endtask

  task automatic rx_overflow();
    logic [DATA_W-1:0] sent [$];
    logic [DATA_W-1:0] word;
    logic [DATA_W-1:0] raw;
    rx_status_t        st;
    int                start;
    start = words_seen;
    for (int i = 0; i < DEPTH + 2; i++) begin
      word = $random(seed);
      if (i < DEPTH) begin
        sent.push_back(word);
      end
      obi_write(DATA_ADDR, word);
    end
    wait_lane_words(start + DEPTH + 2);
    // push or drop lands one cycle after the parity beat
    @(negedge clk);
    obi_read(STATUS_ADDR, raw);
    st = rx_status_t'(raw);
    compare_word("status.count", 32'(st.count), 32'(DEPTH));
    compare_word("status.overflow", 32'(st.overflow), 32'h1);
    compare_word("status.not_empty", 32'(st.not_empty), 32'h1);
    obi_read(STATUS_ADDR, raw);
    st = rx_status_t'(raw);
    compare_word("status.overflow", 32'(st.overflow), 32'h0);
    compare_word("status.count", 32'(st.count), 32'(DEPTH));
    for (int i = 0; i < DEPTH; i++) begin
      obi_read(DATA_ADDR, raw);
      compare_word("rx rdata", raw, sent[i]);
    end
    finish_test("rx_overflow");
  endtask

  task automatic empty_data_read();
    logic [DATA_W-1:0] raw;
    rx_status_t        st;
    obi_read(DATA_ADDR, raw);
    compare_word("rx rdata", raw, 32'h0);
    obi_read(STATUS_ADDR, raw);
    st = rx_status_t'(raw);
    compare_word("status.count", 32'(st.count), 32'h0);
    compare_word("status.not_empty", 32'(st.not_empty), 32'h0);
    finish_test("empty_data_read");
  endtask

  initial begin
    int waited;
    tx_req       = '0;
    rx_req       = '0;
    corrupt_req  = 1'b0;
    seed         = 38;
    test_errors  = 0;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    waited       = 0;
    while (rst_n !== 1'b1 && waited < WAIT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    require(rst_n, "reset was never released");
    reset_state_test();
    single_word_loopback();
    burst_in_order();
    parity_corruption();
    rx_overflow();
    empty_data_read();
    $display("tests run %0d, tests failed %0d, errors %0d",
             tests_run, tests_failed, total_errors);
    if (total_errors == 0 && tests_failed == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- sources.f
src/obi_pkg.sv
src/sl_pkg.sv
src/sl_fifo.sv
src/sl_tx_port.sv
src/sl_serializer.sv
src/sl_deserializer.sv
src/sl_rx_port.sv
src/serial_link_top.sv
sim/sl_fifo_asserts.sv
sim/tb_clk_gen.sv
sim/tb_serial_link.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the serial link testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=tb_serial_link

verilator --binary --timing --assert -f sources.f \
  --top-module "$TOP" -Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG_FILE"; then
  exit 0
else
  echo "pass line not found in $LOG_FILE"
  exit 1
fi
